// File: eth_capture.f
rtl/eth_capture_pkg.sv
rtl/frame_buffer.sv
rtl/time_counter.sv
rtl/frame_rx.sv
rtl/host_regs.sv
rtl/eth_capture_top.sv
sim/tb_eth_capture.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_eth_capture
FILELIST  := eth_capture.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the sim binary exits cleanly either way
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_eth_capture.sv
`timescale 1ns/1ps

module tb_eth_capture;

  import eth_capture_pkg::*;

  // longest test is well under 2000 cycles
  localparam longint CYCLE_LIMIT = 20000;

  logic              clk_125;
  logic              core_rst_n;
  logic [ADDR_W-1:0] awaddr_i;
  logic              awvalid_i;
  logic              awready_o;
  logic [DATA_W-1:0] wdata_i;
  logic [3:0]        wstrb_i;
  logic              wvalid_i;
  logic              wready_o;
  resp_e             bresp_o;
  logic              bvalid_o;
  logic              bready_i;
  logic [ADDR_W-1:0] araddr_i;
  logic              arvalid_i;
  logic              arready_o;
  logic [DATA_W-1:0] rdata_o;
  resp_e             rresp_o;
  logic              rvalid_o;
  logic              rready_i;
  logic              rx_dv_i;
  logic [7:0]        rx_data_i;
  logic              irq_o;

  logic [31:0]       lcg_state = 32'h8398d2c8;
  logic [7:0]        exp_bytes [0:2047];
  longint            cycles = 0;
  longint            first_edge;
  int                errors = 0;
  int                test_start;
  int                tests_ok = 0;
  int                tests_bad = 0;

  eth_capture_top u_eth_capture_top (.*);

  initial begin
    clk_125 = 1'b0;
    forever #20 clk_125 = ~clk_125;
  end

  always @(posedge clk_125) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: the run went past %0d clock cycles without finishing", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  // little-endian word from the expected frame bytes
  function automatic logic [DATA_W-1:0] packed_word(input int w);
    logic [DATA_W-1:0] word;
    for (int b = 0; b < 4; b++) begin
      word[8*b +: 8] = exp_bytes[4*w + b];
    end
    return word;
  endfunction

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input resp_e exp, input resp_e act);
    if (act !== exp) begin
      $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    if (errors == test_start) tests_ok++;
    else tests_bad++;
    $display("%s: %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  // ------------------------------------------------------------
  // bus and line drivers, outputs sampled 5 ns after the falling edge
  // ------------------------------------------------------------
  task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [3:0] strb);
    @(negedge clk_125);
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    #5;
    while (!awready_o) begin
      @(negedge clk_125);
      #5;
    end
    check_bit("wready_o", 1'b1, wready_o);
    @(negedge clk_125);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    #5;
    while (!bvalid_o) begin
      @(negedge clk_125);
      #5;
    end
    check_resp("bresp_o", RESP_OKAY, bresp_o);
  endtask

  task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    @(negedge clk_125);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    #5;
    while (!arready_o) begin
      @(negedge clk_125);
      #5;
    end
    @(negedge clk_125);
    arvalid_i = 1'b0;
    #5;
    while (!rvalid_o) begin
      @(negedge clk_125);
      #5;
    end
    data = rdata_o;
    check_resp("rresp_o", RESP_OKAY, rresp_o);
  endtask

  task automatic send_frame(input int nbytes);
    @(negedge clk_125);
    rx_dv_i = 1'b0;
    repeat (3) @(negedge clk_125);
    first_edge = cycles;
    for (int i = 0; i < nbytes; i++) begin
      exp_bytes[i] = lcg_byte();
      rx_dv_i   = 1'b1;
      rx_data_i = exp_bytes[i];
      @(negedge clk_125);
    end
    rx_dv_i   = 1'b0;
    rx_data_i = 8'h00;
  endtask

  task automatic wait_irq();
    @(negedge clk_125);
    #5;
    while (!irq_o) begin
      @(negedge clk_125);
      #5;
    end
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic test_reset_state();
    logic [DATA_W-1:0] rd;
    axil_read(REG_STATUS, rd);
    check_data("status", 32'h0, rd);
    axil_read(REG_LEN, rd);
    check_data("len", 32'h0, rd);
    axil_read(12'h01C, rd);
    check_data("unmapped 0x01c", 32'h0, rd);
    check_bit("irq_o", 1'b0, irq_o);
    report_test("reset state");
  endtask

  task automatic test_counter_load();
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] lo_a;
    logic [DATA_W-1:0] lo_b;
    axil_write(REG_COUNT_LO, 32'h11223344, 4'b1111);
    axil_write(REG_COUNT_HI, 32'hAABBCCDD, 4'b1000);
    // upper bytes were zero and see no carry from the low half
    axil_read(REG_COUNT_HI, rd);
    check_data("count_hi", 32'hAA000000, rd);
    axil_read(REG_COUNT_LO, lo_a);
    axil_read(REG_COUNT_LO, lo_b);
    check_bit("count_lo_loaded", 1'b1, lo_a >= 32'h11223344);
    check_bit("count_lo_rising", 1'b1, lo_b > lo_a);
    report_test("counter load");
  endtask

  task automatic test_unarmed();
    logic [DATA_W-1:0] rd;
    send_frame(30);
    repeat (4) @(negedge clk_125);
    axil_read(REG_STATUS, rd);
    check_data("status", 32'h0, rd);
    check_bit("irq_o", 1'b0, irq_o);
    report_test("unarmed frame");
  endtask

  task automatic test_capture();
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] mask;
    axil_write(REG_STATUS, 32'h1, 4'b1111);
    send_frame(61);
    wait_irq();
    axil_read(REG_STATUS, rd);
    check_data("status", 32'h2, rd);
    check_bit("irq_o", 1'b1, irq_o);
    axil_read(REG_LEN, rd);
    check_data("len", 32'd61, rd);
    for (int w = 0; w < 16; w++) begin
      for (int b = 0; b < 4; b++) begin
        mask[8*b +: 8] = (4*w + b < 61) ? 8'hFF : 8'h00;
      end
      axil_read(BUF_BASE + ADDR_W'(4*w), rd);
      check_data("buffer word", packed_word(w) & mask, rd & mask);
    end
    report_test("single capture");
  endtask

  task automatic test_timestamps();
    logic [DATA_W-1:0] lo;
    logic [DATA_W-1:0] hi;
    logic [TS_W-1:0]   ts1;
    logic [TS_W-1:0]   delta;
    longint            edge1;
    axil_write(REG_STATUS, 32'h1, 4'b1111);
    send_frame(16);
    edge1 = first_edge;
    wait_irq();
    axil_read(REG_TS_LO, lo);
    axil_read(REG_TS_HI, hi);
    ts1 = {hi, lo};
    axil_write(REG_STATUS, 32'h1, 4'b1111);
    send_frame(24);
    wait_irq();
    axil_read(REG_TS_LO, lo);
    axil_read(REG_TS_HI, hi);
    delta = {hi, lo} - ts1;
    check_data("ts delta lo", DATA_W'(first_edge - edge1), delta[DATA_W-1:0]);
    check_data("ts delta hi", 32'h0, delta[TS_W-1:DATA_W]);
    report_test("timestamp spacing");
  endtask

  task automatic test_backpressure();
    logic [DATA_W-1:0] held;
    @(negedge clk_125);
    rready_i  = 1'b0;
    araddr_i  = BUF_BASE;
    arvalid_i = 1'b1;
    #5;
    while (!arready_o) begin
      @(negedge clk_125);
      #5;
    end
    @(negedge clk_125);
    arvalid_i = 1'b0;
    // arm while the read is outstanding
    awaddr_i  = REG_STATUS;
    wdata_i   = 32'h1;
    wstrb_i   = 4'b1111;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    #5;
    while (!rvalid_o) begin
      @(negedge clk_125);
      #5;
    end
    held = rdata_o;
    check_data("rdata_o", packed_word(0), held);
    repeat (5) begin
      @(negedge clk_125);
      #5;
      check_bit("rvalid_o", 1'b1, rvalid_o);
      check_data("rdata_o", held, rdata_o);
      check_bit("awready_o", 1'b0, awready_o);
      check_bit("wready_o", 1'b0, wready_o);
    end
    @(negedge clk_125);
    rready_i = 1'b1;
    #5;
    while (!awready_o) begin
      @(negedge clk_125);
      #5;
    end
    check_bit("wready_o", 1'b1, wready_o);
    @(negedge clk_125);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    #5;
    while (!bvalid_o) begin
      @(negedge clk_125);
      #5;
    end
    check_resp("bresp_o", RESP_OKAY, bresp_o);
    check_bit("irq_o", 1'b0, irq_o);
    report_test("back-pressure");
  endtask

  initial begin
    core_rst_n = 1'b0;
    awaddr_i   = '0;
    awvalid_i  = 1'b0;
    wdata_i    = '0;
    wstrb_i    = '0;
    wvalid_i   = 1'b0;
    bready_i   = 1'b1;
    araddr_i   = '0;
    arvalid_i  = 1'b0;
    rready_i   = 1'b1;
    rx_dv_i    = 1'b0;
    rx_data_i  = 8'h00;
    test_start = 0;
    repeat (3) @(posedge clk_125);
    @(negedge clk_125);
    core_rst_n = 1'b1;

    test_reset_state();
    test_counter_load();
    test_unarmed();
    test_capture();
    test_timestamps();
    test_backpressure();

    $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: rtl/eth_capture_top.sv
`timescale 1ns/1ps

module eth_capture_top #(
  parameter int BUF_AW = eth_capture_pkg::BUF_AW,
  parameter int LEN_W  = eth_capture_pkg::LEN_W
) (
  input  logic                                 clk_125,
  input  logic                                 core_rst_n,
  input  logic [eth_capture_pkg::ADDR_W-1:0]   awaddr_i,
  input  logic                                 awvalid_i,
  output logic                                 awready_o,
  input  logic [eth_capture_pkg::DATA_W-1:0]   wdata_i,
  input  logic [eth_capture_pkg::DATA_W/8-1:0] wstrb_i,
  input  logic                                 wvalid_i,
  output logic                                 wready_o,
  output eth_capture_pkg::resp_e               bresp_o,
  output logic                                 bvalid_o,
  input  logic                                 bready_i,
  input  logic [eth_capture_pkg::ADDR_W-1:0]   araddr_i,
  input  logic                                 arvalid_i,
  output logic                                 arready_o,
  output logic [eth_capture_pkg::DATA_W-1:0]   rdata_o,
  output eth_capture_pkg::resp_e               rresp_o,
  output logic                                 rvalid_o,
  input  logic                                 rready_i,
  input  logic                                 rx_dv_i,
  input  logic [7:0]                           rx_data_i,
  output logic                                 irq_o
);

  import eth_capture_pkg::*;

  logic [TS_W-1:0]     count;
  logic [TS_W-1:0]     ts;
  logic [LEN_W-1:0]    len;
  logic                arm;
  logic                done_pulse;
  logic                rx_busy;
  logic                wr_en;
  logic [DATA_W/8-1:0] wr_be;
  logic [BUF_AW-1:0]   wr_addr;
  logic [DATA_W-1:0]   wr_data;
  logic [BUF_AW-1:0]   rd_addr;
  logic [DATA_W-1:0]   rd_data;
  logic [DATA_W/8-1:0] load_lo;
  logic [DATA_W/8-1:0] load_hi;
  logic [DATA_W-1:0]   load_data;

  time_counter u_time_counter (
    .clk_125(clk_125), .core_rst_n(core_rst_n),
    .load_lo_i(load_lo), .load_hi_i(load_hi), .load_data_i(load_data),
    .count_o(count)
  );

  frame_rx #(.BUF_AW(BUF_AW), .LEN_W(LEN_W)) u_frame_rx (
    .clk_125(clk_125), .core_rst_n(core_rst_n),
    .rx_dv_i(rx_dv_i), .rx_data_i(rx_data_i), .arm_i(arm), .count_i(count),
    .wr_en_o(wr_en), .wr_be_o(wr_be), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
    .ts_o(ts), .len_o(len), .done_o(done_pulse), .busy_o(rx_busy)
  );

  frame_buffer #(.BUF_AW(BUF_AW)) u_frame_buffer (
    .clk_125(clk_125),
    .wr_en_i(wr_en), .wr_be_i(wr_be), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
    .rd_addr_i(rd_addr), .rd_data_o(rd_data)
  );

  host_regs #(.BUF_AW(BUF_AW), .LEN_W(LEN_W)) u_host_regs (
    .clk_125(clk_125), .core_rst_n(core_rst_n),
    .awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
    .wdata_i(wdata_i), .wstrb_i(wstrb_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
    .bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
    .araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
    .rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o), .rready_i(rready_i),
    .count_i(count), .ts_i(ts), .len_i(len), .done_i(done_pulse), .busy_i(rx_busy),
    .rd_data_i(rd_data), .rd_addr_o(rd_addr), .arm_o(arm),
    .load_lo_o(load_lo), .load_hi_o(load_hi), .load_data_o(load_data),
    .irq_o(irq_o)
  );

endmodule

// File: rtl/host_regs.sv
`timescale 1ns/1ps

module host_regs #(
  parameter int BUF_AW = eth_capture_pkg::BUF_AW,
  parameter int LEN_W  = eth_capture_pkg::LEN_W
) (
  input  logic                                 clk_125,
  input  logic                                 core_rst_n,
  input  logic [eth_capture_pkg::ADDR_W-1:0]   awaddr_i,
  input  logic                                 awvalid_i,
  output logic                                 awready_o,
  input  logic [eth_capture_pkg::DATA_W-1:0]   wdata_i,
  input  logic [eth_capture_pkg::DATA_W/8-1:0] wstrb_i,
  input  logic                                 wvalid_i,
  output logic                                 wready_o,
  output eth_capture_pkg::resp_e               bresp_o,
  output logic                                 bvalid_o,
  input  logic                                 bready_i,
  input  logic [eth_capture_pkg::ADDR_W-1:0]   araddr_i,
  input  logic                                 arvalid_i,
  output logic                                 arready_o,
  output logic [eth_capture_pkg::DATA_W-1:0]   rdata_o,
  output eth_capture_pkg::resp_e               rresp_o,
  output logic                                 rvalid_o,
  input  logic                                 rready_i,
  input  logic [eth_capture_pkg::TS_W-1:0]     count_i,
  input  logic [eth_capture_pkg::TS_W-1:0]     ts_i,
  input  logic [LEN_W-1:0]                     len_i,
  input  logic                                 done_i,
  input  logic                                 busy_i,
  input  logic [eth_capture_pkg::DATA_W-1:0]   rd_data_i,
  output logic [BUF_AW-1:0]                    rd_addr_o,
  output logic                                 arm_o,
  output logic [eth_capture_pkg::DATA_W/8-1:0] load_lo_o,
  output logic [eth_capture_pkg::DATA_W/8-1:0] load_hi_o,
  output logic [eth_capture_pkg::DATA_W-1:0]   load_data_o,
  output logic                                 irq_o
);

  import eth_capture_pkg::*;

  logic              bvalid_q;
  logic              rvalid_q;
  logic              rd_pend_q;
  logic              done_q;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] reg_rdata;
  logic              pending;
  logic              wr_go;
  logic              rd_go;
  logic              rd_buf;
  logic [ADDR_W-1:0] wr_off;
  logic [ADDR_W-1:0] rd_off;

  // ------------------------------------------------------------
  // handshake, one transaction at a time
  // ------------------------------------------------------------
  assign pending = bvalid_q || rvalid_q || rd_pend_q;
  assign wr_go   = awvalid_i && wvalid_i && !pending;
  assign rd_go   = arvalid_i && !pending && !wr_go;

  assign awready_o = wr_go;
  assign wready_o  = wr_go;
  assign arready_o = rd_go;

  assign rd_buf = |(araddr_i & BUF_BASE);
  assign wr_off = {awaddr_i[ADDR_W-1:2], 2'b00};
  assign rd_off = {araddr_i[ADDR_W-1:2], 2'b00};

  // RAM samples the address in the accept cycle
  assign rd_addr_o   = BUF_AW'(araddr_i[ADDR_W-2:2]);
  assign load_data_o = wdata_i;

  // write decode, buffer writes are dropped
  always_comb begin
    arm_o     = 1'b0;
    load_lo_o = '0;
    load_hi_o = '0;
    if (wr_go) begin
      case (wr_off)
        REG_STATUS:   arm_o = wstrb_i[0] && wdata_i[0];
        REG_COUNT_LO: load_lo_o = wstrb_i;
        REG_COUNT_HI: load_hi_o = wstrb_i;
        default:      ;
      endcase
    end
  end

  always_comb begin
    case (rd_off)
      REG_STATUS:   reg_rdata = {{(DATA_W-2){1'b0}}, done_q, busy_i};
      REG_COUNT_LO: reg_rdata = count_i[DATA_W-1:0];
      REG_COUNT_HI: reg_rdata = count_i[TS_W-1:DATA_W];
      REG_TS_LO:    reg_rdata = ts_i[DATA_W-1:0];
      REG_TS_HI:    reg_rdata = ts_i[TS_W-1:DATA_W];
      REG_LEN:      reg_rdata = DATA_W'(len_i);
      default:      reg_rdata = '0;
    endcase
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
      rd_pend_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      if (wr_go) bvalid_q <= 1'b1;
      else if (bready_i) bvalid_q <= 1'b0;

      // buffer reads wait one more cycle for the RAM
      rd_pend_q <= rd_go && rd_buf;
      if ((rd_go && !rd_buf) || rd_pend_q) rvalid_q <= 1'b1;
      else if (rready_i) rvalid_q <= 1'b0;

      // a finishing frame wins over a clear
      if (done_i) done_q <= 1'b1;
      else if (arm_o) done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_125) begin
    if (rd_go && !rd_buf) rdata_q <= reg_rdata;
    else if (rd_pend_q) rdata_q <= rd_data_i;
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = RESP_OKAY;
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = RESP_OKAY;
  assign irq_o    = done_q;

endmodule

// File: rtl/frame_rx.sv
`timescale 1ns/1ps

module frame_rx #(
  parameter int BUF_AW = eth_capture_pkg::BUF_AW,
  parameter int LEN_W  = eth_capture_pkg::LEN_W
) (
  input  logic                                clk_125,
  input  logic                                core_rst_n,
  input  logic                                rx_dv_i,
  input  logic [7:0]                          rx_data_i,
  input  logic                                arm_i,
  input  logic [eth_capture_pkg::TS_W-1:0]    count_i,
  output logic                                wr_en_o,
  output logic [eth_capture_pkg::DATA_W/8-1:0] wr_be_o,
  output logic [BUF_AW-1:0]                   wr_addr_o,
  output logic [eth_capture_pkg::DATA_W-1:0]  wr_data_o,
  output logic [eth_capture_pkg::TS_W-1:0]    ts_o,
  output logic [LEN_W-1:0]                    len_o,
  output logic                                done_o,
  output logic                                busy_o
);

  import eth_capture_pkg::*;

  localparam int LANES  = DATA_W / 8;
  localparam int LANE_W = $clog2(LANES);

  rx_state_e          state_q;
  logic [BUF_AW-1:0]  waddr_q;
  logic [LANE_W-1:0]  lane_q;
  logic               full_q;
  logic [LEN_W-1:0]   cnt_q;
  logic               store;

  assign store  = rx_dv_i && (state_q == RX_READY || state_q == RX_LOAD);
  assign busy_o = (state_q != RX_OFF);

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      state_q <= RX_OFF;
      waddr_q <= '0;
      lane_q  <= '0;
      full_q  <= 1'b0;
      cnt_q   <= '0;
      ts_o    <= '0;
      len_o   <= '0;
      done_o  <= 1'b0;
      wr_en_o <= 1'b0;
    end else begin
      done_o  <= 1'b0;
      wr_en_o <= 1'b0;
      case (state_q)
        RX_OFF: begin
          if (arm_i) state_q <= RX_WAIT_IDLE;
        end
        // skip any frame already on the line
        RX_WAIT_IDLE: begin
          waddr_q <= '0;
          lane_q  <= '0;
          full_q  <= 1'b0;
          cnt_q   <= '0;
          if (!rx_dv_i) state_q <= RX_READY;
        end
        RX_READY: begin
          if (rx_dv_i) begin
            ts_o    <= count_i;
            state_q <= RX_LOAD;
          end
        end
        RX_LOAD: begin
          if (!rx_dv_i) begin
            len_o   <= cnt_q;
            done_o  <= 1'b1;
            state_q <= RX_OFF;
          end
        end
        default: state_q <= RX_OFF;
      endcase

      if (store) begin
        wr_en_o <= !full_q;
        // length keeps counting past a full buffer, saturating
        if (cnt_q != '1) cnt_q <= cnt_q + 1'b1;
        lane_q <= lane_q + 1'b1;
        if (&lane_q) begin
          if (&waddr_q) full_q <= 1'b1;
          else waddr_q <= waddr_q + 1'b1;
        end
      end
    end
  end

  // little-endian byte packing
  always_ff @(posedge clk_125) begin
    if (store) begin
      wr_addr_o <= waddr_q;
      wr_be_o   <= {{(LANES-1){1'b0}}, 1'b1} << lane_q;
      wr_data_o <= {LANES{rx_data_i}};
    end
  end

endmodule

// File: rtl/time_counter.sv
`timescale 1ns/1ps

module time_counter (
  input  logic                                clk_125,
  input  logic                                core_rst_n,
  input  logic [eth_capture_pkg::DATA_W/8-1:0] load_lo_i,
  input  logic [eth_capture_pkg::DATA_W/8-1:0] load_hi_i,
  input  logic [eth_capture_pkg::DATA_W-1:0]  load_data_i,
  output logic [eth_capture_pkg::TS_W-1:0]    count_o
);

  import eth_capture_pkg::*;

  logic [TS_W-1:0] count_q;
  logic [TS_W-1:0] count_next;

  // strobed bytes replace the incremented value
  always_comb begin
    count_next = count_q + 1'b1;
    for (int b = 0; b < DATA_W/8; b++) begin
      if (load_lo_i[b]) begin
        count_next[8*b +: 8] = load_data_i[8*b +: 8];
      end
      if (load_hi_i[b]) begin
        count_next[DATA_W + 8*b +: 8] = load_data_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_next;
    end
  end

  assign count_o = count_q;

endmodule

// File: rtl/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer #(
  parameter int BUF_AW = eth_capture_pkg::BUF_AW
) (
  input  logic                                clk_125,
  input  logic                                wr_en_i,
  input  logic [eth_capture_pkg::DATA_W/8-1:0] wr_be_i,
  input  logic [BUF_AW-1:0]                   wr_addr_i,
  input  logic [eth_capture_pkg::DATA_W-1:0]  wr_data_i,
  input  logic [BUF_AW-1:0]                   rd_addr_i,
  output logic [eth_capture_pkg::DATA_W-1:0]  rd_data_o
);

  import eth_capture_pkg::*;

  logic [DATA_W-1:0] mem [0:2**BUF_AW-1];

  // byte lanes written independently
  always_ff @(posedge clk_125) begin
    if (wr_en_i) begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (wr_be_i[b]) begin
          mem[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

  // one cycle read latency
  always_ff @(posedge clk_125) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// File: rtl/eth_capture_pkg.sv
package eth_capture_pkg;

  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  localparam int BUF_AW = 9;
  localparam int LEN_W  = 12;
  localparam int TS_W   = 64;

  // ------------------------------------------------------------
  // host register map
  // ------------------------------------------------------------
  typedef enum logic [ADDR_W-1:0] {
    REG_STATUS   = 12'h000,
    REG_COUNT_LO = 12'h004,
    REG_COUNT_HI = 12'h008,
    REG_TS_LO    = 12'h010,
    REG_TS_HI    = 12'h014,
    REG_LEN      = 12'h018
  } reg_addr_e;

  // address bit 11 selects the frame buffer window
  localparam logic [ADDR_W-1:0] BUF_BASE = 12'h800;

  // receive FSM
  typedef enum logic [1:0] {
    RX_WAIT_IDLE = 2'b01,
    RX_READY     = 2'b10,
    RX_LOAD      = 2'b11,
    RX_OFF       = 2'b00
  } rx_state_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage
